// File: hw/avmm_mux_defs.svh
// Avalon-MM 1-to-4 bridge constants
// Bus widths, target port count, address windows and response codes
`ifndef AVMM_MUX_DEFS_SVH
`define AVMM_MUX_DEFS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define AVMM_ADDR_W     32
`define AVMM_DATA_W     32
`define AVMM_BEN_W      (`AVMM_DATA_W / 8)
`define AVMM_RESP_W     2

// ----------------------------------------------------------
// Target ports and their inclusive address windows
// ----------------------------------------------------------
`define AVMM_N_PORTS    4

`define AVMM_WIN0_LO    32'h0000_0000
`define AVMM_WIN0_HI    32'h0000_01FF
`define AVMM_WIN1_LO    32'h0000_0200
`define AVMM_WIN1_HI    32'h0000_02FF
`define AVMM_WIN2_LO    32'h0000_0300
`define AVMM_WIN2_HI    32'h0000_03FF
`define AVMM_WIN3_LO    32'h0000_0400
`define AVMM_WIN3_HI    32'hFFFF_FFFF

// Avalon response encodings
`define AVMM_RESP_OKAY   2'b00
`define AVMM_RESP_SLVERR 2'b10

`endif

// File: hw/avmm_bus_pkg.sv
// Avalon-MM bus types
// Vector types for the address, data, byte enable and response fields

`include "avmm_mux_defs.svh"

package avmm_bus_pkg;

    // Byte address on both sides of the bridge
    typedef logic [`AVMM_ADDR_W-1:0] addr_t;

    // One data word, read or write
    typedef logic [`AVMM_DATA_W-1:0] data_t;

    // One enable bit per byte lane of data_t
    typedef logic [`AVMM_BEN_W-1:0] ben_t;

    // Response code carried back with read data and write responses
    typedef logic [`AVMM_RESP_W-1:0] resp_t;

endpackage

// File: hw/avmm_map_pkg.sv
// Avalon-MM bridge port map types
// Target port index and the host and target state machine encodings

`include "avmm_mux_defs.svh"

package avmm_map_pkg;

    // Selects one of the downstream target ports
    typedef logic [$clog2(`AVMM_N_PORTS)-1:0] port_idx_t;

    // Upstream side: waiting for a command, stalled on a target, completing
    typedef enum logic [1:0] {
        HOST_IDLE = 2'd0,
        HOST_BUSY = 2'd1,
        HOST_DONE = 2'd2
    } host_state_t;

    // Downstream side: idle, holding the command, waiting for the answer
    typedef enum logic [1:0] {
        TGT_IDLE = 2'd0,
        TGT_CMD  = 2'd1,
        TGT_WAIT = 2'd2
    } target_state_t;

endpackage

// File: hw/avmm_host_port.sv
// Upstream Avalon-MM port of the 1-to-4 bridge
// Decodes the address to a target port, registers the command and stalls
// the host with waitrequest until the chosen target reports done

`include "avmm_mux_defs.svh"

module avmm_host_port (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        avs_chipselect,
    input  logic                        avs_read,
    input  logic                        avs_write,
    input  avmm_bus_pkg::addr_t         avs_address,
    input  avmm_bus_pkg::data_t         avs_writedata,
    input  avmm_bus_pkg::ben_t          avs_byteenable,
    output logic                        avs_waitrequest,
    output avmm_bus_pkg::data_t         avs_readdata,
    output logic                        avs_readdatavalid,
    output avmm_bus_pkg::resp_t         avs_response,
    output logic                        avs_writeresponsevalid,
    output logic [`AVMM_N_PORTS-1:0]    req,
    output logic                        cmd_read,
    output avmm_bus_pkg::addr_t         cmd_address,
    output avmm_bus_pkg::data_t         cmd_writedata,
    output avmm_bus_pkg::ben_t          cmd_byteenable,
    input  logic [`AVMM_N_PORTS-1:0]    done,
    input  avmm_bus_pkg::data_t         done_readdata [`AVMM_N_PORTS],
    input  avmm_bus_pkg::resp_t         done_response [`AVMM_N_PORTS]
);
    import avmm_bus_pkg::*;
    import avmm_map_pkg::*;

    localparam addr_t WIN_LO [`AVMM_N_PORTS] = '{
        `AVMM_WIN0_LO, `AVMM_WIN1_LO, `AVMM_WIN2_LO, `AVMM_WIN3_LO
    };
    localparam addr_t WIN_HI [`AVMM_N_PORTS] = '{
        `AVMM_WIN0_HI, `AVMM_WIN1_HI, `AVMM_WIN2_HI, `AVMM_WIN3_HI
    };

    host_state_t                state;
    port_idx_t                  dec_idx;
    port_idx_t                  port_idx;
    logic                       accept;
    logic [`AVMM_N_PORTS-1:0]   sel_mask;
    logic                       sel_done;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------

    // Walk the windows from the top so the lowest matching port wins
    always_comb begin
        dec_idx = '0;
        for (int i = `AVMM_N_PORTS - 1; i >= 0; i--) begin
            if (avs_address >= WIN_LO[i] && avs_address <= WIN_HI[i]) begin
                dec_idx = port_idx_t'(i);
            end
        end
    end

    assign accept   = avs_chipselect && (avs_read || avs_write) && !avs_waitrequest;
    assign sel_mask = {{(`AVMM_N_PORTS-1){1'b0}}, 1'b1} << port_idx;
    assign sel_done = |(done & sel_mask);

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------

    // The completion cycle already shows waitrequest low, so a new command
    // may be taken in HOST_DONE just as in HOST_IDLE
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state                  <= HOST_IDLE;
            avs_waitrequest        <= 1'b1;
            avs_readdatavalid      <= 1'b0;
            avs_writeresponsevalid <= 1'b0;
            req                    <= '0;
        end else begin
            req <= '0;
            case (state)
                HOST_IDLE, HOST_DONE: begin
                    avs_readdatavalid      <= 1'b0;
                    avs_writeresponsevalid <= 1'b0;
                    if (accept) begin
                        avs_waitrequest <= 1'b1;
                        req             <= {{(`AVMM_N_PORTS-1){1'b0}}, 1'b1} << dec_idx;
                        state           <= HOST_BUSY;
                    end else begin
                        avs_waitrequest <= 1'b0;
                        state           <= HOST_IDLE;
                    end
                end
                HOST_BUSY: begin
                    if (sel_done) begin
                        avs_waitrequest        <= 1'b0;
                        avs_readdatavalid      <= cmd_read;
                        avs_writeresponsevalid <= !cmd_read;
                        state                  <= HOST_DONE;
                    end
                end
                default: begin
                    state <= HOST_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Command and response registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            port_idx       <= dec_idx;
            cmd_read       <= avs_read;
            cmd_address    <= avs_address;
            cmd_writedata  <= avs_writedata;
            cmd_byteenable <= avs_byteenable;
        end
        if (state == HOST_BUSY && sel_done) begin
            avs_response <= done_response[port_idx];
            if (cmd_read) begin
                avs_readdata <= done_readdata[port_idx];
            end
        end
    end

    // Only one completion strobe at a time towards the host
    a_valid_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(avs_readdatavalid && avs_writeresponsevalid))
        else $error("read and write completion valid high together");

    a_no_accept_busy: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> (state != HOST_BUSY))
        else $error("command accepted while a transaction is outstanding");

    // A target may only finish the transaction it was handed
    a_done_from_sel: assert property (@(posedge clk) disable iff (!rstn)
        (|done) |-> (state == HOST_BUSY) && (done == sel_mask))
        else $error("done from a port that holds no command");

endmodule

// File: hw/avmm_target_port.sv
// Downstream Avalon-MM port of the 1-to-4 bridge
// Issues one command from the host port, holds it through waitrequest
// and returns the read data or write response with a done pulse

`include "avmm_mux_defs.svh"

module avmm_target_port (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req,
    input  logic                cmd_read,
    input  avmm_bus_pkg::addr_t cmd_address,
    input  avmm_bus_pkg::data_t cmd_writedata,
    input  avmm_bus_pkg::ben_t  cmd_byteenable,
    output logic                avm_chipselect,
    output logic                avm_read,
    output logic                avm_write,
    output avmm_bus_pkg::addr_t avm_address,
    output avmm_bus_pkg::data_t avm_writedata,
    output avmm_bus_pkg::ben_t  avm_byteenable,
    input  logic                avm_waitrequest,
    input  avmm_bus_pkg::data_t avm_readdata,
    input  logic                avm_readdatavalid,
    input  avmm_bus_pkg::resp_t avm_response,
    input  logic                avm_writeresponsevalid,
    output logic                done,
    output avmm_bus_pkg::data_t done_readdata,
    output avmm_bus_pkg::resp_t done_response
);
    import avmm_map_pkg::*;

    target_state_t  state;
    logic           answer;

    // The host keeps cmd_read steady until done, so it still tells
    // which kind of answer to wait for
    assign answer = cmd_read ? avm_readdatavalid : avm_writeresponsevalid;

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state          <= TGT_IDLE;
            avm_chipselect <= 1'b0;
            avm_read       <= 1'b0;
            avm_write      <= 1'b0;
            done           <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                TGT_IDLE: begin
                    if (req) begin
                        avm_chipselect <= 1'b1;
                        avm_read       <= cmd_read;
                        avm_write      <= !cmd_read;
                        state          <= TGT_CMD;
                    end
                end
                TGT_CMD: begin
                    // Command taken by the target once waitrequest is low
                    if (!avm_waitrequest) begin
                        avm_read  <= 1'b0;
                        avm_write <= 1'b0;
                        state     <= TGT_WAIT;
                    end
                end
                TGT_WAIT: begin
                    if (answer) begin
                        avm_chipselect <= 1'b0;
                        done           <= 1'b1;
                        state          <= TGT_IDLE;
                    end
                end
                default: begin
                    state <= TGT_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Command and answer payload
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == TGT_IDLE && req) begin
            avm_address    <= cmd_address;
            avm_writedata  <= cmd_writedata;
            avm_byteenable <= cmd_byteenable;
        end
        if (state == TGT_WAIT && answer) begin
            done_response <= avm_response;
            if (cmd_read) begin
                done_readdata <= avm_readdata;
            end
        end
    end

    a_rw_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(avm_read && avm_write))
        else $error("avm_read and avm_write high together");

    // A stalled command must not change under the target
    a_cmd_stable: assert property (@(posedge clk) disable iff (!rstn)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable({avm_read, avm_write, avm_address, avm_writedata, avm_byteenable}))
        else $error("command changed while waitrequest was high");

endmodule

// File: hw/avmm_mux_top.sv
// Avalon-MM 1-to-4 bridge top level
// One host port feeding four target ports, one per address window

`include "avmm_mux_defs.svh"

module avmm_mux_top (
    input  logic                        clk,
    input  logic                        rstn,
    // Upstream slave side
    input  logic                        avs_chipselect,
    input  logic                        avs_read,
    input  logic                        avs_write,
    input  avmm_bus_pkg::addr_t         avs_address,
    input  avmm_bus_pkg::data_t         avs_writedata,
    input  avmm_bus_pkg::ben_t          avs_byteenable,
    output logic                        avs_waitrequest,
    output avmm_bus_pkg::data_t         avs_readdata,
    output logic                        avs_readdatavalid,
    output avmm_bus_pkg::resp_t         avs_response,
    output logic                        avs_writeresponsevalid,
    // Downstream master side, indexed by target port
    output logic [`AVMM_N_PORTS-1:0]    avm_chipselect,
    output logic [`AVMM_N_PORTS-1:0]    avm_read,
    output logic [`AVMM_N_PORTS-1:0]    avm_write,
    output avmm_bus_pkg::addr_t         avm_address [`AVMM_N_PORTS],
    output avmm_bus_pkg::data_t         avm_writedata [`AVMM_N_PORTS],
    output avmm_bus_pkg::ben_t          avm_byteenable [`AVMM_N_PORTS],
    input  logic [`AVMM_N_PORTS-1:0]    avm_waitrequest,
    input  avmm_bus_pkg::data_t         avm_readdata [`AVMM_N_PORTS],
    input  logic [`AVMM_N_PORTS-1:0]    avm_readdatavalid,
    input  avmm_bus_pkg::resp_t         avm_response [`AVMM_N_PORTS],
    input  logic [`AVMM_N_PORTS-1:0]    avm_writeresponsevalid
);
    import avmm_bus_pkg::*;

    // Shared command bundle and per-port completion lines
    logic [`AVMM_N_PORTS-1:0]   req;
    logic                       cmd_read;
    addr_t                      cmd_address;
    data_t                      cmd_writedata;
    ben_t                       cmd_byteenable;
    logic [`AVMM_N_PORTS-1:0]   done;
    data_t                      done_readdata [`AVMM_N_PORTS];
    resp_t                      done_response [`AVMM_N_PORTS];

    avmm_host_port u_host (
        .clk                    (clk),
        .rstn                   (rstn),
        .avs_chipselect         (avs_chipselect),
        .avs_read               (avs_read),
        .avs_write              (avs_write),
        .avs_address            (avs_address),
        .avs_writedata          (avs_writedata),
        .avs_byteenable         (avs_byteenable),
        .avs_waitrequest        (avs_waitrequest),
        .avs_readdata           (avs_readdata),
        .avs_readdatavalid      (avs_readdatavalid),
        .avs_response           (avs_response),
        .avs_writeresponsevalid (avs_writeresponsevalid),
        .req                    (req),
        .cmd_read               (cmd_read),
        .cmd_address            (cmd_address),
        .cmd_writedata          (cmd_writedata),
        .cmd_byteenable         (cmd_byteenable),
        .done                   (done),
        .done_readdata          (done_readdata),
        .done_response          (done_response)
    );

    for (genvar g = 0; g < `AVMM_N_PORTS; g++) begin : g_tgt
        avmm_target_port u_tgt (
            .clk                    (clk),
            .rstn                   (rstn),
            .req                    (req[g]),
            .cmd_read               (cmd_read),
            .cmd_address            (cmd_address),
            .cmd_writedata          (cmd_writedata),
            .cmd_byteenable         (cmd_byteenable),
            .avm_chipselect         (avm_chipselect[g]),
            .avm_read               (avm_read[g]),
            .avm_write              (avm_write[g]),
            .avm_address            (avm_address[g]),
            .avm_writedata          (avm_writedata[g]),
            .avm_byteenable         (avm_byteenable[g]),
            .avm_waitrequest        (avm_waitrequest[g]),
            .avm_readdata           (avm_readdata[g]),
            .avm_readdatavalid      (avm_readdatavalid[g]),
            .avm_response           (avm_response[g]),
            .avm_writeresponsevalid (avm_writeresponsevalid[g]),
            .done                   (done[g]),
            .done_readdata          (done_readdata[g]),
            .done_response          (done_response[g])
        );
    end

endmodule

// File: dv/avmm_target_model.sv
// Behavioral Avalon-MM target memory for one bridge port
// Adds wait states and response delay, reads unwritten words as a fill pattern

`include "avmm_mux_defs.svh"

module avmm_target_model (
    input  logic                    clk,
    input  logic                    rstn,
    input  avmm_map_pkg::port_idx_t port_num,
    input  logic [2:0]              wait_cycles,
    input  logic [2:0]              delay_cycles,
    input  logic                    avm_chipselect,
    input  logic                    avm_read,
    input  logic                    avm_write,
    input  avmm_bus_pkg::addr_t     avm_address,
    input  avmm_bus_pkg::data_t     avm_writedata,
    input  avmm_bus_pkg::ben_t      avm_byteenable,
    output logic                    avm_waitrequest,
    output avmm_bus_pkg::data_t     avm_readdata,
    output logic                    avm_readdatavalid,
    output avmm_bus_pkg::resp_t     avm_response,
    output logic                    avm_writeresponsevalid
);
    import avmm_bus_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_STALL,
        M_RESP
    } model_state_t;

    model_state_t state = M_IDLE;
    data_t        mem [logic [29:0]];
    logic [2:0]   wcnt = '0;
    logic [2:0]   dcnt = '0;
    logic         is_read = 1'b0;
    addr_t        addr_q = '0;
    data_t        wdata_q = '0;
    ben_t         ben_q = '0;
    data_t        old_word;
    logic         wait_q = 1'b1;
    data_t        rdata_q = '0;
    resp_t        resp_q = `AVMM_RESP_OKAY;
    logic         rdv_q = 1'b0;
    logic         wrv_q = 1'b0;

    assign avm_waitrequest        = wait_q;
    assign avm_readdata           = rdata_q;
    assign avm_readdatavalid      = rdv_q;
    assign avm_response           = resp_q;
    assign avm_writeresponsevalid = wrv_q;

    // Outputs move on the falling edge so the DUT samples them stable
    always @(negedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= M_IDLE;
            wait_q <= 1'b1;
            rdv_q  <= 1'b0;
            wrv_q  <= 1'b0;
        end else begin
            rdv_q <= 1'b0;
            wrv_q <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (avm_chipselect && (avm_read || avm_write)) begin
                        is_read <= avm_read;
                        addr_q  <= avm_address;
                        wdata_q <= avm_writedata;
                        ben_q   <= avm_byteenable;
                        wcnt    <= wait_cycles;
                        wait_q  <= (wait_cycles != 3'd0);
                        state   <= M_STALL;
                    end
                end
                M_STALL: begin
                    // The edge just passed saw waitrequest low, so the command is taken
                    if (!wait_q) begin
                        if (mem.exists(addr_q[31:2])) begin
                            old_word = mem[addr_q[31:2]];
                        end else begin
                            old_word = {6'b0, port_num, addr_q[23:0]};
                        end
                        if (is_read) begin
                            rdata_q <= old_word;
                        end else begin
                            for (int b = 0; b < `AVMM_BEN_W; b++) begin
                                if (ben_q[b]) begin
                                    old_word[b*8 +: 8] = wdata_q[b*8 +: 8];
                                end
                            end
                            mem[addr_q[31:2]] = old_word;
                        end
                        resp_q <= (addr_q[7:2] == 6'h3F) ? `AVMM_RESP_SLVERR : `AVMM_RESP_OKAY;
                        dcnt   <= delay_cycles;
                        wait_q <= 1'b1;
                        state  <= M_RESP;
                    end else begin
                        wcnt <= wcnt - 3'd1;
                        if (wcnt == 3'd1) begin
                            wait_q <= 1'b0;
                        end
                    end
                end
                default: begin
                    if (dcnt != 3'd0) begin
                        dcnt <= dcnt - 3'd1;
                    end else begin
                        rdv_q <= is_read;
                        wrv_q <= !is_read;
                        state <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: dv/tb_avmm_mux.sv
// Testbench for the Avalon-MM 1-to-4 bridge
// Random reads and writes over all windows against four target models

`include "avmm_mux_defs.svh"

module tb_avmm_mux;
    timeunit 1ns;
    timeprecision 1ps;
    import avmm_bus_pkg::*;
    import avmm_map_pkg::*;

    localparam logic [31:0] SEED    = 32'hbfe12aaa;
    localparam int          TIMEOUT = 300;
    localparam int          N_TXN   = 400;

    logic clk = 1'b0;
    logic rstn = 1'b0;
    logic avs_chipselect = 1'b0;
    logic avs_read = 1'b0;
    logic avs_write = 1'b0;
    addr_t avs_address = '0;
    data_t avs_writedata = '0;
    ben_t avs_byteenable = '0;
    logic avs_waitrequest;
    data_t avs_readdata;
    logic avs_readdatavalid;
    resp_t avs_response;
    logic avs_writeresponsevalid;
    logic [`AVMM_N_PORTS-1:0] avm_chipselect;
    logic [`AVMM_N_PORTS-1:0] avm_read;
    logic [`AVMM_N_PORTS-1:0] avm_write;
    addr_t avm_address [`AVMM_N_PORTS];
    data_t avm_writedata [`AVMM_N_PORTS];
    ben_t avm_byteenable [`AVMM_N_PORTS];
    logic [`AVMM_N_PORTS-1:0] avm_waitrequest;
    data_t avm_readdata [`AVMM_N_PORTS];
    logic [`AVMM_N_PORTS-1:0] avm_readdatavalid;
    resp_t avm_response [`AVMM_N_PORTS];
    logic [`AVMM_N_PORTS-1:0] avm_writeresponsevalid;

    logic [31:0] rng = SEED;
    logic [31:0] lat_rng = ~SEED;
    data_t ref_mem [logic [29:0]];
    port_idx_t exp_port = '0;
    addr_t exp_addr = '0;
    data_t exp_wdata = '0;
    ben_t exp_ben = '0;
    logic exp_read = 1'b0;
    data_t exp_rdata = '0;
    resp_t exp_resp = '0;
    logic idle_phase = 1'b1;
    logic pending = 1'b0;
    int err_cnt = 0;
    int timeout_cnt = 0;
    logic accept;
    logic compl;
    logic [`AVMM_N_PORTS-1:0] exp_sel;

    assign accept  = avs_chipselect && (avs_read || avs_write) && !avs_waitrequest;
    assign compl   = avs_readdatavalid || avs_writeresponsevalid;
    assign exp_sel = {{(`AVMM_N_PORTS-1){1'b0}}, 1'b1} << exp_port;

    avmm_mux_top dut (.*);

    for (genvar g = 0; g < `AVMM_N_PORTS; g++) begin : g_model
        avmm_target_model u_model (
            .clk(clk), .rstn(rstn), .port_num(port_idx_t'(g)),
            .wait_cycles(lat_rng[g*6 +: 3]), .delay_cycles(lat_rng[g*6+3 +: 3]),
            .avm_chipselect(avm_chipselect[g]), .avm_read(avm_read[g]),
            .avm_write(avm_write[g]), .avm_address(avm_address[g]),
            .avm_writedata(avm_writedata[g]), .avm_byteenable(avm_byteenable[g]),
            .avm_waitrequest(avm_waitrequest[g]), .avm_readdata(avm_readdata[g]),
            .avm_readdatavalid(avm_readdatavalid[g]), .avm_response(avm_response[g]),
            .avm_writeresponsevalid(avm_writeresponsevalid[g])
        );
    end

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic port_idx_t decode_port(input addr_t a);
        if (a <= `AVMM_WIN0_HI) return 2'd0;
        if (a <= `AVMM_WIN1_HI) return 2'd1;
        if (a <= `AVMM_WIN2_HI) return 2'd2;
        return 2'd3;
    endfunction

    // Picks a word aligned address in window r[1:0] and sometimes forces it onto an SLVERR word
    function automatic addr_t pick_addr(input logic [31:0] r);
        addr_t a;
        case (r[1:0])
            2'd0:    a = r & 32'h0000_01FC;
            2'd1:    a = 32'h0000_0200 | (r & 32'h0000_00FC);
            2'd2:    a = 32'h0000_0300 | (r & 32'h0000_00FC);
            default: a = (r & 32'hFFFF_FFFC) | 32'h0000_0400;
        endcase
        if (r[30:28] == 3'd0) a[7:2] = 6'h3F;
        return a;
    endfunction

    // Wait states and delays change every cycle and each model latches them per command
    always @(posedge clk) lat_rng <= xorshift(lat_rng);

    always @(posedge clk or negedge rstn) begin
        if (!rstn) pending <= 1'b0;
        else pending <= (pending && !compl) || accept;
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn) idle_phase |->
        (avm_chipselect == '0 && avm_read == '0 && avm_write == '0 && !compl))
        else begin
            $display("MISMATCH t=%0t idle outputs expected 0 actual cs=%b rd=%b wr=%b v=%b",
                $time, $sampled(avm_chipselect), $sampled(avm_read), $sampled(avm_write),
                $sampled(compl));
            err_cnt++;
        end
    a_cs_port: assert property (@(posedge clk) disable iff (!rstn)
        (|avm_chipselect) |-> avm_chipselect == exp_sel)
        else begin
            $display("MISMATCH t=%0t avm_chipselect expected %b actual %b",
                $time, $sampled(exp_sel), $sampled(avm_chipselect));
            err_cnt++;
        end
    a_cmd_kind: assert property (@(posedge clk) disable iff (!rstn)
        (avm_read[exp_port] || avm_write[exp_port]) |-> avm_read[exp_port] == exp_read)
        else begin
            $display("MISMATCH t=%0t avm_read expected %b actual %b",
                $time, $sampled(exp_read), $sampled(avm_read[exp_port]));
            err_cnt++;
        end
    a_cmd_addr: assert property (@(posedge clk) disable iff (!rstn)
        (avm_read[exp_port] || avm_write[exp_port]) |-> avm_address[exp_port] == exp_addr)
        else begin
            $display("MISMATCH t=%0t avm_address expected %h actual %h",
                $time, $sampled(exp_addr), $sampled(avm_address[exp_port]));
            err_cnt++;
        end
    a_cmd_ben: assert property (@(posedge clk) disable iff (!rstn)
        (avm_read[exp_port] || avm_write[exp_port]) |-> avm_byteenable[exp_port] == exp_ben)
        else begin
            $display("MISMATCH t=%0t avm_byteenable expected %h actual %h",
                $time, $sampled(exp_ben), $sampled(avm_byteenable[exp_port]));
            err_cnt++;
        end
    a_cmd_wdata: assert property (@(posedge clk) disable iff (!rstn)
        avm_write[exp_port] |-> avm_writedata[exp_port] == exp_wdata)
        else begin
            $display("MISMATCH t=%0t avm_writedata expected %h actual %h",
                $time, $sampled(exp_wdata), $sampled(avm_writedata[exp_port]));
            err_cnt++;
        end
    a_rdata: assert property (@(posedge clk) disable iff (!rstn)
        avs_readdatavalid |-> avs_readdata == exp_rdata)
        else begin
            $display("MISMATCH t=%0t avs_readdata expected %h actual %h",
                $time, $sampled(exp_rdata), $sampled(avs_readdata));
            err_cnt++;
        end
    a_resp: assert property (@(posedge clk) disable iff (!rstn)
        compl |-> avs_response == exp_resp)
        else begin
            $display("MISMATCH t=%0t avs_response expected %h actual %h",
                $time, $sampled(exp_resp), $sampled(avs_response));
            err_cnt++;
        end
    a_compl_kind: assert property (@(posedge clk) disable iff (!rstn)
        compl |-> avs_readdatavalid == exp_read)
        else begin
            $display("MISMATCH t=%0t avs_readdatavalid expected %b actual %b",
                $time, $sampled(exp_read), $sampled(avs_readdatavalid));
            err_cnt++;
        end
    a_one_compl: assert property (@(posedge clk) disable iff (!rstn) compl |-> pending)
        else begin
            $display("Completion seen at %0t with no command outstanding", $time);
            err_cnt++;
        end
    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        accept |-> (!pending || compl))
        else begin
            $display("Command accepted at %0t while one was outstanding", $time);
            err_cnt++;
        end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic run_txn(input logic rd, input addr_t a, input data_t d, input ben_t b);
        int n;
        data_t old;
        for (n = 0; n < TIMEOUT && avs_waitrequest; n++) @(negedge clk);
        if (avs_waitrequest) begin
            $display("Timeout at %0t waiting for avs_waitrequest to drop", $time);
            timeout_cnt++;
            return;
        end
        exp_port = decode_port(a);
        old = ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : {6'b0, exp_port, a[23:0]};
        if (rd) begin
            exp_rdata = old;
        end else begin
            for (int i = 0; i < `AVMM_BEN_W; i++) begin
                if (b[i]) old[i*8 +: 8] = d[i*8 +: 8];
            end
            ref_mem[a[31:2]] = old;
        end
        exp_resp   = (a[7:2] == 6'h3F) ? `AVMM_RESP_SLVERR : `AVMM_RESP_OKAY;
        exp_addr   = a;
        exp_wdata  = d;
        exp_ben    = b;
        exp_read   = rd;
        idle_phase = 1'b0;
        avs_chipselect = 1'b1;
        avs_read       = rd;
        avs_write      = !rd;
        avs_address    = a;
        avs_writedata  = d;
        avs_byteenable = b;
        @(negedge clk);
        // The command stays presented while the bridge is busy, so a second accept would show
        for (n = 0; n < TIMEOUT && !compl; n++) @(negedge clk);
        avs_chipselect = 1'b0;
        avs_read       = 1'b0;
        avs_write      = 1'b0;
        if (!compl) begin
            $display("Timeout at %0t waiting for completion of address %h", $time, a);
            timeout_cnt++;
            return;
        end
        // Expected values stay put until the completion cycle has been sampled
        @(negedge clk);
    endtask

    initial begin
        addr_t a;
        data_t d;
        ben_t b;
        int n;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (n = 0; n < 2 && avs_waitrequest; n++) @(negedge clk);
        if (avs_waitrequest) begin
            $display("avs_waitrequest stayed high more than two cycles after reset");
            err_cnt++;
        end
        for (int i = 0; i < N_TXN && timeout_cnt == 0; i++) begin
            rng = xorshift(rng);
            a = pick_addr(rng);
            rng = xorshift(rng);
            d = rng;
            rng = xorshift(rng);
            b = rng[3:0];
            if (rng[8]) begin
                run_txn(1'b0, a, d, b);
            end
            run_txn(1'b1, a, '0, 4'hF);
        end
        $display("Errors: %0d check failures, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: avmm_mux.f
+incdir+hw
hw/avmm_bus_pkg.sv
hw/avmm_map_pkg.sv
hw/avmm_host_port.sv
hw/avmm_target_port.sv
hw/avmm_mux_top.sv
dv/avmm_target_model.sv
dv/tb_avmm_mux.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        ?= tb_avmm_mux
RTL_TOP    ?= avmm_mux_top
FILELIST   ?= avmm_mux.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
